// File: list.f
verilog/st_bus_pkg.sv
verilog/st_sys_pkg.sv
verilog/rtc_bus_if.sv
verilog/reset_seq.sv
verilog/clk_enables.sv
verilog/rtc_rp5c15.sv
verilog/audio_mixer.sv
verilog/st_glue_top.sv
testbench/st_glue_checker.sv
testbench/tb_st_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the st glue testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f list.f \
	--top-module tb_st_glue \
	-o sim_st_glue

./obj_dir/sim_st_glue | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

// File: testbench/tb_st_glue.sv
`timescale 1ns/1ns

module tb_st_glue import st_bus_pkg::*, st_sys_pkg::*; ();

	localparam int ENABLE_WINDOW = 32_085;	// about one millisecond of clk_32
	localparam int ACK_WAIT      = 16;
	localparam int RAND_SAMPLES  = 32;
	// reset 16, two sequences of 128, enable window, table and random samples
	// stay far below this
	localparam int MAX_CYCLES    = 60_000;

	localparam logic [2:0] OP_WR      = 3'd0;
	localparam logic [2:0] OP_RD      = 3'd1;
	localparam logic [2:0] OP_AUD     = 3'd2;
	localparam logic [2:0] OP_EXT_RST = 3'd3;
	localparam logic [2:0] OP_TIME    = 3'd4;	// idx 0 zero time, else fixed time

	// dow 3, 28.06.(19)94 with year field 14, 12:37:45
	localparam logic [RTC_TIME_W-1:0] TIME_FIXED =
		{4'h3, 8'h14, 8'h06, 8'h28, 8'h12, 8'h37, 8'h45};

	typedef struct packed {
		logic [2:0]           op;
		logic [RTC_ADR_W-1:0] idx;
		logic [WB_DAT_W-1:0]  wdat;
		logic [WB_DAT_W-1:0]  exp;
		logic [YM_W-1:0]      ym;
		logic [DMA_W-1:0]     dl;
		logic [DMA_W-1:0]     dr;
	} row_t;

	logic                  clk_32        = 1'b0;
	logic                  xsint         = 1'b0;	// power-on reset held from time 0
	logic                  ext_reset_n_i = 1'b1;
	logic                  wb_cyc_i      = 1'b0;
	logic                  wb_stb_i      = 1'b0;
	logic                  wb_we_i       = 1'b0;
	logic [RTC_ADR_W-1:0]  wb_adr_i      = '0;
	logic [WB_DAT_W-1:0]   wb_dat_i      = '0;
	logic [RTC_TIME_W-1:0] rtc_time_i    = TIME_FIXED;
	logic [YM_W-1:0]       ym_level_i    = 10'd512;	// mid-scale, silence
	logic [DMA_W-1:0]      dma_l_i       = 8'd128;
	logic [DMA_W-1:0]      dma_r_i       = 8'd128;
	logic [WB_DAT_W-1:0]   wb_dat_o;
	logic                  wb_ack_o;
	logic [MIX_W-1:0]      mix_l_o;
	logic [MIX_W-1:0]      mix_r_o;
	logic                  sys_reset_o;
	logic                  mcu_reset_n_o;
	logic                  periph_en_o;
	logic                  slow_en_o;

	row_t table_q[$];
	int   seed       = 32;
	int   cycle_cnt  = 0;
	int   checks     = 0;
	int   mismatches = 0;
	int   failures   = 0;	// handshake and sequence problems

	st_glue_top uut (.*);

	always #50 clk_32 = ~clk_32;	// 100 ns period

	always @(posedge clk_32) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
			$display("summary: %0d checks, %0d mismatches, %0d other failures",
				checks, mismatches, failures);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// mixer rule in plain integer arithmetic
	// psg: (level-512)*16 plus its top four bits, dma: (smp-128)*64 plus top six
	function automatic logic [MIX_W-1:0] mix_expected(input int ym, input int dma);
		int psg;
		int smp;
		psg = (ym - 512) * 16 + ((ym + 512) % 1024) / 64;
		smp = (dma - 128) * 64 + ((dma + 128) % 256) / 4;
		return MIX_W'(psg + smp);	// 15 bit wrap
	endfunction

	function automatic void add_row(input logic [2:0] op, input int idx, input int wdat,
		input int exp);
		row_t r;
		r      = '0;
		r.op   = op;
		r.idx  = RTC_ADR_W'(idx);
		r.wdat = WB_DAT_W'(wdat);
		r.exp  = WB_DAT_W'(exp);
		table_q.push_back(r);
	endfunction

	function automatic void add_audio(input int ym, input int dl, input int dr);
		row_t r;
		r    = '0;
		r.op = OP_AUD;
		r.ym = YM_W'(ym);
		r.dl = DMA_W'(dl);
		r.dr = DMA_W'(dr);
		table_q.push_back(r);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			$display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			mismatches++;
		end
	endtask

	// one wishbone classic cycle, inputs change right after a rising edge
	task automatic wb_access(input logic we, input logic [RTC_ADR_W-1:0] adr,
		input logic [WB_DAT_W-1:0] dat, output logic [WB_DAT_W-1:0] rdat, output bit acked);
		int wait_cnt;
		wait_cnt = 0;
		acked    = 1'b0;
		rdat     = '0;
		@(posedge clk_32);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		while (!acked && wait_cnt < ACK_WAIT) begin
			@(negedge clk_32);	// sample mid-cycle
			wait_cnt++;
			if (wb_ack_o) begin
				acked = 1'b1;
				rdat  = wb_dat_o;
			end
		end
		@(posedge clk_32);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		assert (acked) else begin
			$display("rtc %s at index %0d got no acknowledge", we ? "write" : "read", adr);
			failures++;
		end
	endtask

	// counts edges from the release edge until sys_reset_o drops
	task automatic measure_reset(input string what);
		int  cyc;
		int  low;
		bit  done;
		cyc  = 0;
		low  = 0;
		done = 1'b0;
		while (!done && cyc < 4 * (RESET_CNT_INIT + 1)) begin
			@(posedge clk_32);
			cyc++;
			@(negedge clk_32);
			if (!mcu_reset_n_o)
				low++;
			if (!sys_reset_o)
				done = 1'b1;
		end
		assert (done) else begin
			$display("%s: sys_reset_o never went low", what);
			failures++;
		end
		check_value("sys_reset_o release cycles", 32'(RESET_CNT_INIT + 1), 32'(cyc));
		check_value("mcu_reset_n_o low cycles", 32'(MCU_RST_START - MCU_RST_END + 1), 32'(low));
	endtask

	task automatic run_enable_window();
		int periph_cnt;
		int slow_cnt;
		int slow_est;
		int last_slow;
		int est;
		periph_cnt = 0;
		slow_cnt   = 0;
		last_slow  = -1;
		est = int'(longint'(ENABLE_WINDOW) * longint'(PERIPH_CLOCK) / longint'(SYSTEM_CLOCK));
		slow_est = ENABLE_WINDOW / (2 ** SLOW_DIV_W);
		for (int n = 0; n < ENABLE_WINDOW; n++) begin
			@(negedge clk_32);
			if (periph_en_o)
				periph_cnt++;
			if (slow_en_o) begin
				slow_cnt++;
				if (last_slow >= 0)
					check_value("slow_en_o period", 32'(2 ** SLOW_DIV_W), 32'(n - last_slow));
				last_slow = n;
			end
		end
		checks++;
		assert (periph_cnt >= est - 1 && periph_cnt <= est + 1) else begin
			$display("Mismatch at %0t ns: periph_en_o count expected %0d +-1, got %0d",
				$time, est, periph_cnt);
			mismatches++;
		end
		// window phase decides whether one more pulse fits
		checks++;
		assert (slow_cnt >= slow_est && slow_cnt <= slow_est + 1) else begin
			$display("Mismatch at %0t ns: slow_en_o count expected %0d to %0d, got %0d",
				$time, slow_est, slow_est + 1, slow_cnt);
			mismatches++;
		end
	endtask

	task automatic apply_audio(input logic [YM_W-1:0] ym, input logic [DMA_W-1:0] dl,
		input logic [DMA_W-1:0] dr);
		logic [MIX_W-1:0] exp_l;
		logic [MIX_W-1:0] exp_r;
		exp_l = mix_expected(int'(ym), int'(dl));
		exp_r = mix_expected(int'(ym), int'(dr));	// mono psg on both sides
		@(posedge clk_32);
		ym_level_i <= ym;
		dma_l_i    <= dl;
		dma_r_i    <= dr;
		@(posedge clk_32);	// registered mixer
		@(negedge clk_32);
		check_value("mix_l_o", 32'(exp_l), 32'(mix_l_o));
		check_value("mix_r_o", 32'(exp_r), 32'(mix_r_o));
	endtask

	task automatic apply_row(input row_t row);
		logic [WB_DAT_W-1:0] rdat;
		bit                  acked;
		case (row.op)
			OP_WR: wb_access(1'b1, row.idx, row.wdat, rdat, acked);
			OP_RD: begin
				wb_access(1'b0, row.idx, 8'h00, rdat, acked);
				if (acked)
					check_value("wb_dat_o", 32'(row.exp), 32'(rdat));
			end
			OP_AUD: apply_audio(row.ym, row.dl, row.dr);
			OP_EXT_RST: begin
				@(posedge clk_32);
				ext_reset_n_i <= 1'b0;
				@(posedge clk_32);
				ext_reset_n_i <= 1'b1;	// this edge samples the button low
				measure_reset("button reset");
			end
			OP_TIME: begin
				@(posedge clk_32);
				rtc_time_i <= (row.idx == '0) ? '0 : TIME_FIXED;
			end
			default: begin
				$display("unknown table operation %0d", row.op);
				failures++;
			end
		endcase
	endtask

	task automatic build_table();
		add_row(OP_WR, 3, 'h0a, 0);	// bank 0 writes land in scratch
		add_row(OP_WR, 7, 'h05, 0);
		add_row(OP_WR, 12, 'h3e, 0);	// upper nibble dropped
		add_row(OP_RD, 0, 0, 'hf5);	// sec lo
		add_row(OP_RD, 1, 0, 'hf4);
		add_row(OP_RD, 2, 0, 'hf7);	// min
		add_row(OP_RD, 3, 0, 'hf3);
		add_row(OP_RD, 4, 0, 'hf2);	// hour
		add_row(OP_RD, 5, 0, 'hf1);
		add_row(OP_RD, 6, 0, 'hf3);	// day of week
		add_row(OP_RD, 7, 0, 'hf8);	// day
		add_row(OP_RD, 8, 0, 'hf2);
		add_row(OP_RD, 9, 0, 'hf6);	// month
		add_row(OP_RD, 10, 0, 'hf0);
		add_row(OP_RD, 11, 0, 'hf6);	// year lo 4 plus 2
		add_row(OP_RD, 12, 0, 'hf1);
		add_row(OP_RD, 13, 0, 'hf8);	// bank 0
		add_row(OP_RD, 14, 0, 'hf0);
		add_row(OP_RD, 15, 0, 'hfc);
		add_row(OP_WR, 13, 'h01, 0);	// select bank 1
		add_row(OP_RD, 13, 0, 'hf9);
		add_row(OP_RD, 3, 0, 'hfa);
		add_row(OP_RD, 7, 0, 'hf5);
		add_row(OP_RD, 12, 0, 'hfe);
		add_row(OP_RD, 14, 0, 'hf0);
		add_row(OP_RD, 15, 0, 'hfc);
		add_row(OP_EXT_RST, 0, 0, 0);	// bank back to 0
		add_row(OP_RD, 13, 0, 'hf8);
		add_row(OP_RD, 3, 0, 'hf3);
		add_row(OP_TIME, 0, 0, 0);	// time word gone, chip looks absent
		add_row(OP_RD, 0, 0, 'hff);
		add_row(OP_RD, 5, 0, 'hff);
		add_row(OP_RD, 13, 0, 'hff);
		add_row(OP_RD, 15, 0, 'hff);
		add_row(OP_TIME, 1, 0, 0);
		add_audio(512, 128, 128);	// silence
		add_audio(1023, 255, 0);	// extremes
		add_audio(0, 0, 255);
		add_audio(300, 90, 200);
	endtask

	initial begin
		logic [YM_W-1:0]  ym_r;
		logic [DMA_W-1:0] dl_r;
		logic [DMA_W-1:0] dr_r;
		build_table();
		repeat (16) @(posedge clk_32);
		xsint <= 1'b1;
		measure_reset("power-on reset");
		run_enable_window();
		for (int i = 0; i < table_q.size(); i++)
			apply_row(table_q[i]);
		for (int k = 0; k < RAND_SAMPLES; k++) begin
			ym_r = YM_W'($random(seed));
			dl_r = DMA_W'($random(seed));
			dr_r = DMA_W'($random(seed));
			apply_audio(ym_r, dl_r, dr_r);
		end
		@(negedge clk_32);
		$display("summary: %0d checks, %0d mismatches, %0d other failures",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: testbench/st_glue_checker.sv
`timescale 1ns/1ns

module st_glue_checker (
	input logic clk_32,
	input logic xsint,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic sys_reset_i,
	input logic mcu_reset_n_i,
	input logic periph_en_i
);

	// ack only answers a request seen on the cycle before
	ack_follows_req: assert property (@(posedge clk_32) disable iff (!xsint)
		ack_i |-> $past(cyc_i && stb_i))
		else $error("wishbone ack without a request on the previous cycle");

	ack_one_cycle: assert property (@(posedge clk_32) disable iff (!xsint)
		ack_i |=> !ack_i)
		else $error("wishbone ack held for two cycles");

	// controller pulse sits inside the system reset
	mcu_in_sys_reset: assert property (@(posedge clk_32) disable iff (!xsint)
		!mcu_reset_n_i |-> sys_reset_i)
		else $error("mcu reset active outside the system reset");

	periph_en_single: assert property (@(posedge clk_32) disable iff (!xsint)
		periph_en_i |=> !periph_en_i)
		else $error("periph enable high on two cycles in a row");

endmodule

bind st_glue_top st_glue_checker u_checker (
	.clk_32        (clk_32),
	.xsint         (xsint),
	.cyc_i         (wb_cyc_i),
	.stb_i         (wb_stb_i),
	.ack_i         (wb_ack_o),
	.sys_reset_i   (sys_reset_o),
	.mcu_reset_n_i (mcu_reset_n_o),
	.periph_en_i   (periph_en_o)
);

// File: verilog/st_glue_top.sv
`timescale 1ns/1ns

module st_glue_top import st_bus_pkg::*, st_sys_pkg::*; (
	input  logic                  clk_32,
	input  logic                  xsint,		// power-on reset, active low
	input  logic                  ext_reset_n_i,	// reset button

	// wishbone slave, rtc registers
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [RTC_ADR_W-1:0]  wb_adr_i,
	input  logic [WB_DAT_W-1:0]   wb_dat_i,
	output logic [WB_DAT_W-1:0]   wb_dat_o,
	output logic                  wb_ack_o,

	input  logic [RTC_TIME_W-1:0] rtc_time_i,	// from io controller

	// audio
	input  logic [YM_W-1:0]       ym_level_i,
	input  logic [DMA_W-1:0]      dma_l_i,
	input  logic [DMA_W-1:0]      dma_r_i,
	output logic [MIX_W-1:0]      mix_l_o,
	output logic [MIX_W-1:0]      mix_r_o,

	output logic                  sys_reset_o,
	output logic                  mcu_reset_n_o,
	output logic                  periph_en_o,	// 2.4576 mhz enable
	output logic                  slow_en_o		// clk_32 / 16
);

	logic sys_reset;

	rtc_bus_if rtc_bus ();

	// wishbone pins onto the master side
	assign rtc_bus.cyc   = wb_cyc_i;
	assign rtc_bus.stb   = wb_stb_i;
	assign rtc_bus.we    = wb_we_i;
	assign rtc_bus.adr   = wb_adr_i;
	assign rtc_bus.dat_w = wb_dat_i;
	assign wb_dat_o      = rtc_bus.dat_r;
	assign wb_ack_o      = rtc_bus.ack;

	assign sys_reset_o = sys_reset;	// also the peripheral reset

	reset_seq u_reset_seq (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.ext_reset_n_i (ext_reset_n_i),
		.sys_reset_o   (sys_reset),
		.mcu_reset_n_o (mcu_reset_n_o)
	);

	clk_enables u_clk_enables (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.periph_en_o (periph_en_o),
		.slow_en_o   (slow_en_o)
	);

	rtc_rp5c15 u_rtc (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.sys_reset_i (sys_reset),
		.bus         (rtc_bus.slave),
		.time_i      (rtc_time_i)
	);

	audio_mixer u_mixer (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.sys_reset_i (sys_reset),
		.ym_level_i  (ym_level_i),
		.dma_l_i     (dma_l_i),
		.dma_r_i     (dma_r_i),
		.mix_l_o     (mix_l_o),
		.mix_r_o     (mix_r_o)
	);

endmodule

// File: verilog/audio_mixer.sv
`timescale 1ns/1ns

module audio_mixer import st_sys_pkg::*; (
	input  logic             clk_32,
	input  logic             xsint,
	input  logic             sys_reset_i,
	input  logic [YM_W-1:0]  ym_level_i,
	input  logic [DMA_W-1:0] dma_l_i,
	input  logic [DMA_W-1:0] dma_r_i,
	output logic [MIX_W-1:0] mix_l_o,
	output logic [MIX_W-1:0] mix_r_o
);

	logic [YM_W-1:0]  ym_s;	// psg, offset removed
	logic [MIX_W-1:0] ym_wide;
	logic [MIX_W-1:0] dma_l_wide;
	logic [MIX_W-1:0] dma_r_wide;

	// ste dma sample to 15 bit signed
	// sign bit on top, top bits repeated below to fill the range
	function automatic logic [MIX_W-1:0] widen_dma(input logic [DMA_W-1:0] smp);
		logic [DMA_W-1:0] s;
		s = smp - {1'b1, {(DMA_W-1){1'b0}}};	// minus 128
		return {s[DMA_W-1], s, s[DMA_W-1 -: MIX_W-DMA_W-1]};
	endfunction

	// psg is mono, same level feeds both sides
	assign ym_s    = ym_level_i - {1'b1, {(YM_W-1){1'b0}}};	// minus 512
	assign ym_wide = {ym_s[YM_W-1], ym_s, ym_s[YM_W-1 -: MIX_W-YM_W-1]};

	assign dma_l_wide = widen_dma(dma_l_i);
	assign dma_r_wide = widen_dma(dma_r_i);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else if (sys_reset_i) begin
			mix_l_o <= '0;	// silence while the system is in reset
			mix_r_o <= '0;
		end else begin
			mix_l_o <= ym_wide + dma_l_wide;	// wraps like the dac adder
			mix_r_o <= ym_wide + dma_r_wide;
		end
	end

endmodule

// File: verilog/rtc_rp5c15.sv
`timescale 1ns/1ns

module rtc_rp5c15 import st_bus_pkg::*; (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  sys_reset_i,
	rtc_bus_if.slave              bus,
	input  logic [RTC_TIME_W-1:0] time_i
);

	logic                 bank;	// 0 time, 1 scratch
	logic                 busy;	// acked, waiting for stb to drop
	logic                 ack_q;
	logic [WB_DAT_W-1:0]  dat_q;
	logic [RTC_NIB_W-1:0] rd_nib;
	logic                 req;
	logic                 take;	// new request accepted this cycle
	logic                 wr_en;

	// bank 1 scratch nibbles, contents unknown until written
	logic [RTC_NIB_W-1:0] scratch [2**RTC_ADR_W];

	assign req   = bus.cyc & bus.stb;
	assign take  = req & ~busy & ~sys_reset_i;
	assign wr_en = take & bus.we;

	assign bus.ack   = ack_q;
	assign bus.dat_r = dat_q;

	// read decode
	always_comb begin
		if (bus.adr == RTC_REG_BANK)
			rd_nib = {1'b1, 2'b00, bank};
		else if (bus.adr == RTC_REG_TEST)
			rd_nib = '0;
		else if (bus.adr == RTC_REG_RESET)
			rd_nib = 4'hc;
		else if (bank)
			rd_nib = scratch[bus.adr];
		else begin
			case (bus.adr)
				4'd0:    rd_nib = time_i[3:0];	// sec
				4'd1:    rd_nib = time_i[7:4];
				4'd2:    rd_nib = time_i[11:8];	// min
				4'd3:    rd_nib = time_i[15:12];
				4'd4:    rd_nib = time_i[19:16];	// hour
				4'd5:    rd_nib = time_i[23:20];
				4'd6:    rd_nib = time_i[51:48];	// day of week
				4'd7:    rd_nib = time_i[27:24];	// day
				4'd8:    rd_nib = time_i[31:28];
				4'd9:    rd_nib = time_i[35:32];	// month
				4'd10:   rd_nib = time_i[39:36];
				4'd11:   rd_nib = time_i[43:40] + RTC_YEAR_FIX;	// year, 1980 based
				4'd12:   rd_nib = time_i[47:44];
				default: rd_nib = RTC_OPEN_NIB;
			endcase
		end
		// no valid time from the io controller, chip reads as open bus
		if (time_i == '0)
			rd_nib = RTC_OPEN_NIB;
	end

	// handshake and bank register
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ack_q <= 1'b0;
			busy  <= 1'b0;
			bank  <= 1'b0;
		end else if (sys_reset_i) begin
			ack_q <= 1'b0;
			busy  <= 1'b0;
			bank  <= 1'b0;
		end else begin
			ack_q <= take;	// single cycle
			if (take)
				busy <= 1'b1;
			else if (!bus.stb)
				busy <= 1'b0;	// rearm once stb has gone low
			if (wr_en && bus.adr == RTC_REG_BANK)
				bank <= bus.dat_w[0];
		end
	end

	// read data, held with ack
	always_ff @(posedge clk_32) begin
		if (take)
			dat_q <= {RTC_UPPER_FILL, rd_nib};
	end

	// any write other than the mode register lands in scratch, either bank
	always_ff @(posedge clk_32) begin
		if (wr_en && bus.adr != RTC_REG_BANK)
			scratch[bus.adr] <= bus.dat_w[RTC_NIB_W-1:0];
	end

endmodule

// File: verilog/clk_enables.sv
`timescale 1ns/1ns

module clk_enables import st_sys_pkg::*; (
	input  logic clk_32,
	input  logic xsint,
	output logic periph_en_o,
	output logic slow_en_o
);

	logic [CLK_ACC_W-1:0]  acc;	// fractional phase
	logic                  periph_en_q;
	logic [SLOW_DIV_W-1:0] slow_cnt;
	logic                  slow_en_q;

	assign periph_en_o = periph_en_q;
	assign slow_en_o   = slow_en_q;

	// 2.4576 mhz out of ~32 mhz without a pll
	// pulse whenever the phase wraps past the system clock
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc         <= '0;
			periph_en_q <= 1'b0;
		end else begin
			periph_en_q <= 1'b0;
			if (acc < CLK_ACC_W'(SYSTEM_CLOCK)) begin
				acc <= acc + CLK_ACC_W'(PERIPH_CLOCK);
			end else begin
				acc         <= acc - CLK_ACC_W'(SYSTEM_CLOCK) + CLK_ACC_W'(PERIPH_CLOCK);
				periph_en_q <= 1'b1;	// one cycle after the wrap
			end
		end
	end

	// free running divide by 16, psg rate
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			slow_cnt  <= '0;
			slow_en_q <= 1'b0;
		end else begin
			slow_en_q <= (slow_cnt == '0);
			slow_cnt  <= slow_cnt + 1'b1;	// wraps
		end
	end

endmodule

// File: verilog/reset_seq.sv
`timescale 1ns/1ns

module reset_seq import st_sys_pkg::*; (
	input  logic clk_32,
	input  logic xsint,
	input  logic ext_reset_n_i,
	output logic sys_reset_o,
	output logic mcu_reset_n_o
);

	logic [RESET_CNT_W-1:0] reset_cnt;	// counts down to zero after release
	logic                   sys_reset_q;
	logic                   mcu_reset_n_q;

	assign sys_reset_o   = sys_reset_q;
	assign mcu_reset_n_o = mcu_reset_n_q;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_cnt     <= RESET_CNT_W'(RESET_CNT_INIT);
			sys_reset_q   <= 1'b1;
			mcu_reset_n_q <= 1'b1;	// controller stays out of reset at power-on
		end else begin
			// drops one cycle after the count hits zero
			sys_reset_q <= (reset_cnt != '0);

			if (reset_cnt != '0)
				reset_cnt <= reset_cnt - 1'b1;
			if (!ext_reset_n_i)
				reset_cnt <= RESET_CNT_W'(RESET_CNT_INIT);	// button restarts the sequence

			// short pulse late in the countdown
			// the controller must keep running for the memory side
			if (reset_cnt == RESET_CNT_W'(MCU_RST_START))
				mcu_reset_n_q <= 1'b0;
			else if (reset_cnt < RESET_CNT_W'(MCU_RST_END))
				mcu_reset_n_q <= 1'b1;
		end
	end

endmodule

// File: verilog/rtc_bus_if.sv
`timescale 1ns/1ns

// wishbone classic register bus, top to rtc
interface rtc_bus_if import st_bus_pkg::*; ();

	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [RTC_ADR_W-1:0] adr;
	logic [WB_DAT_W-1:0]  dat_w;	// master to slave
	logic [WB_DAT_W-1:0]  dat_r;	// slave to master, valid with ack
	logic                 ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

// File: verilog/st_sys_pkg.sv
package st_sys_pkg;

	// clock rates in hz
	localparam int unsigned SYSTEM_CLOCK = 32_084_988;	// clk_32 nominal
	localparam int unsigned PERIPH_CLOCK = 2_457_600;	// mfp timer clock

	// fractional divider accumulator
	localparam int CLK_ACC_W = 32;

	// free counter for the 1-in-16 enable
	localparam int SLOW_DIV_W = 4;

	// power-on / external reset sequencing
	localparam int RESET_CNT_W    = 7;
	localparam int RESET_CNT_INIT = 127;	// cycles held in reset after release
	localparam int MCU_RST_START  = 10;	// controller reset pulse starts here
	localparam int MCU_RST_END    = 8;	// and ends once the count drops below this

	// audio sample widths
	localparam int YM_W  = 10;	// psg level, unsigned, mid-scale 512
	localparam int DMA_W = 8;	// ste dma sound, unsigned, mid-scale 128
	localparam int MIX_W = 15;	// summed output per side, signed

endpackage

// File: verilog/st_bus_pkg.sv
package st_bus_pkg;

	// register bus
	localparam int RTC_ADR_W = 4;	// rp5c15 has 16 nibble registers
	localparam int WB_DAT_W  = 8;	// byte wide wishbone data
	localparam int RTC_NIB_W = 4;

	// packed time word from the io controller, low to high
	//   [7:0] sec, [15:8] min, [23:16] hour
	//   [31:24] day, [39:32] month, [47:40] year
	//   [51:48] day of week
	// all two digit fields are bcd, low digit in the low nibble
	localparam int RTC_TIME_W = 52;

	// bank 0 index map
	//   0/1 sec lo/hi   2/3 min lo/hi    4/5 hour lo/hi
	//   6 day of week   7/8 day lo/hi    9/10 month lo/hi
	//   11/12 year lo/hi
	// indices 13..15 are the same in both banks
	// bank 1 indices 0..12 are scratch nibbles
	localparam logic [RTC_ADR_W-1:0] RTC_REG_BANK  = 4'd13;	// mode register, bank in bit 0
	localparam logic [RTC_ADR_W-1:0] RTC_REG_TEST  = 4'd14;	// test register, reads 0
	localparam logic [RTC_ADR_W-1:0] RTC_REG_RESET = 4'd15;	// reset register, reads c

	// gemdos counts years from 1980
	localparam logic [RTC_NIB_W-1:0] RTC_YEAR_FIX = 4'd2;

	// no time from the io controller yet, chip looks absent
	localparam logic [RTC_NIB_W-1:0] RTC_OPEN_NIB = 4'hf;

	// upper data lines are not driven by the chip
	localparam logic [WB_DAT_W-RTC_NIB_W-1:0] RTC_UPPER_FILL = 4'hf;

endpackage
